// File: src/agen_defs.svh
`ifndef AGEN_DEFS_SVH
`define AGEN_DEFS_SVH

// address and data path width
`define AGEN_ADDR_W 32

// segment register ids
`define AGEN_SEG_ID_W 3
`define AGEN_NUM_SEGS 8

// stack segment id, checked for stack accesses
`define AGEN_SEG_SS 2

// string pointer units, 0 is source (esi/ds), 1 is destination (edi/es)
`define AGEN_NUM_STR_PTRS 2

// mem_size code width
`define AGEN_SIZE_W 2

`endif

// File: src/agen_pkg.sv
`default_nettype none

`include "agen_defs.svh"

package agen_pkg;

   // uop control word, msb first
   typedef struct packed {
      logic [2:0] rsvd;
      logic       mux_imm1;
      logic       repne_steady;
      logic       cmps_first;
      logic       cmps_second;
      logic [1:0] rd_addr_sel;
      logic [1:0] wr_addr_sel;
      logic       jmp_stall;
      logic       near_ret;
      logic       far_ret;
      logic       ld_flags;
      logic       df_affected;
   } uop_ctrl_t;

   // decoded control for the stage
   typedef struct packed {
      logic [`AGEN_NUM_STR_PTRS-1:0] ptr_load;
      logic                          steady;
      logic                          second_uop;
      logic [1:0]                    rd_addr_sel;
      logic [1:0]                    wr_addr_sel;
      logic                          imm1;
   } agen_ctrl_t;

   // result of one string pointer unit
   typedef struct packed {
      logic [`AGEN_ADDR_W-1:0]   lin_addr;
      logic [`AGEN_ADDR_W-1:0]   base_offset;
      logic [`AGEN_SEG_ID_W-1:0] seg_id;
   } str_ptr_t;

   typedef logic [`AGEN_NUM_SEGS-1:0][`AGEN_ADDR_W-1:0] seg_limits_t;

   typedef logic signed [`AGEN_ADDR_W-1:0] step_t;

   // +1/+2/+4 bytes, negated when df is set
   function automatic step_t calc_step(input logic [`AGEN_SIZE_W-1:0] size, input logic df);
      step_t mag;
      case (size)
         2'd0:    mag = 1;
         2'd1:    mag = 2;
         default: mag = 4;
      endcase
      return df ? -mag : mag;
   endfunction

endpackage

`default_nettype wire

// File: src/agen_ctrl_decode.sv
`timescale 1ns/10ps
`default_nettype none

module agen_ctrl_decode
   import agen_pkg::*;
(
   input  logic       v,
   input  logic       ld_me,
   input  uop_ctrl_t  uop,
   output agen_ctrl_t ctrl,
   output logic       jmp_stall,
   output logic       v_ld_df
);

   logic ld_valid;

   // pointer state only moves on a valid latch load
   assign ld_valid = ld_me & v;

   always_comb begin
      ctrl = '0;
      // source unit on first cmps uop, destination on second
      ctrl.ptr_load[0] = ld_valid & uop.cmps_first;
      ctrl.ptr_load[1] = ld_valid & uop.cmps_second;
      ctrl.steady      = uop.repne_steady;
      ctrl.second_uop  = uop.cmps_second;
      ctrl.rd_addr_sel = uop.rd_addr_sel;
      ctrl.wr_addr_sel = uop.wr_addr_sel;
      ctrl.imm1        = uop.mux_imm1;
   end

   // stall fetch on jumps and returns
   assign jmp_stall = v & (uop.jmp_stall | uop.near_ret | uop.far_ret);

   // df load only when flags written and df actually affected
   assign v_ld_df = v & uop.ld_flags & uop.df_affected;

endmodule

`default_nettype wire

// File: src/string_ptr_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "agen_defs.svh"

module string_ptr_unit
   import agen_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      load,
   input  logic                      steady,
   input  logic [`AGEN_ADDR_W-1:0]   a,
   input  logic [`AGEN_SEG_ID_W-1:0] seg_id_in,
   input  logic [`AGEN_ADDR_W-1:0]   seg_base,
   input  step_t                     step,
   output str_ptr_t                  ptr
);

   logic [`AGEN_ADDR_W-1:0]   ptr_q;
   logic [`AGEN_ADDR_W-1:0]   lin_q;
   logic [`AGEN_SEG_ID_W-1:0] seg_q;
   logic [`AGEN_ADDR_W-1:0]   first_lin;
   logic [`AGEN_ADDR_W-1:0]   ptr_nxt;
   logic [`AGEN_ADDR_W-1:0]   lin_nxt;

   // first iteration address comes straight from the register operand
   assign first_lin = a + seg_base;

   // current access
   always_comb begin
      ptr.lin_addr    = steady ? lin_q + step : first_lin;
      ptr.base_offset = steady ? ptr_q : a;
      ptr.seg_id      = steady ? seg_q : seg_id_in;
   end

   // advance by the signed operand size
   assign ptr_nxt = (steady ? ptr_q : a) + step;
   assign lin_nxt = (steady ? lin_q : first_lin) + step;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr_q <= '0;
         lin_q <= '0;
         seg_q <= '0;
      end else if (load) begin
         ptr_q <= ptr_nxt;
         lin_q <= lin_nxt;
         // segment latched only on the first iteration
         if (!steady) begin
            seg_q <= seg_id_in;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/seg_limit_check.sv
`timescale 1ns/10ps
`default_nettype none

`include "agen_defs.svh"

module seg_limit_check
   import agen_pkg::*;
(
   input  logic                      v,
   input  logic                      mem_rd,
   input  logic                      mem_wr,
   input  agen_ctrl_t                ctrl,
   input  logic                      repne,
   input  logic [`AGEN_SEG_ID_W-1:0] seg1,
   input  logic [`AGEN_SIZE_W-1:0]   mem_size,
   input  logic [`AGEN_ADDR_W-1:0]   base_disp,
   input  logic [`AGEN_ADDR_W-1:0]   sib_si,
   input  logic [`AGEN_ADDR_W-1:0]   sp,
   input  logic [`AGEN_ADDR_W-1:0]   str_offset,
   input  logic [`AGEN_SEG_ID_W-1:0] str_seg,
   input  seg_limits_t               seg_limits,
   output logic                      seg_limit_exc
);

   logic                      stack_acc;
   logic                      str_acc;
   logic [`AGEN_ADDR_W-1:0]   offset;
   logic [`AGEN_SEG_ID_W-1:0] seg;
   logic [`AGEN_ADDR_W-1:0]   size_m1;
   logic [`AGEN_ADDR_W:0]     acc_end;

   assign stack_acc = (mem_rd & (ctrl.rd_addr_sel == 2'd1)) |
                      (mem_wr & (ctrl.wr_addr_sel == 2'd1));
   assign str_acc   = repne & ctrl.steady;

   always_comb begin
      if (stack_acc) begin
         offset = sp;
         seg    = `AGEN_SEG_ID_W'(`AGEN_SEG_SS);
      end else if (str_acc) begin
         offset = str_offset;
         seg    = str_seg;
      end else begin
         offset = base_disp + sib_si;
         seg    = seg1;
      end
   end

   // last byte touched, relative to offset
   always_comb begin
      case (mem_size)
         2'd0:    size_m1 = 32'd0;
         2'd1:    size_m1 = 32'd1;
         default: size_m1 = 32'd3;
      endcase
   end

   // one extra bit so a wrapping access still faults
   assign acc_end = {1'b0, offset} + {1'b0, size_m1};

   assign seg_limit_exc = v & (mem_rd | mem_wr) & (acc_end > {1'b0, seg_limits[seg]});

endmodule

`default_nettype wire

// File: src/addr_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "agen_defs.svh"

module addr_route
   import agen_pkg::*;
(
   input  agen_ctrl_t                              ctrl,
   input  str_ptr_t [`AGEN_NUM_STR_PTRS-1:0]       ptr,
   input  logic [`AGEN_ADDR_W-1:0]                 seg_sum,
   input  logic [`AGEN_ADDR_W-1:0]                 stack_addr,
   input  logic [`AGEN_ADDR_W-1:0]                 intr_addr,
   input  logic [`AGEN_ADDR_W-1:0]                 a,
   input  logic [`AGEN_ADDR_W-1:0]                 b,
   input  logic                                    repne,
   output logic [`AGEN_ADDR_W-1:0]                 mem_rd_addr,
   output logic [`AGEN_ADDR_W-1:0]                 mem_wr_addr,
   output logic [`AGEN_ADDR_W-1:0]                 a_out,
   output logic [`AGEN_ADDR_W-1:0]                 b_out,
   output logic [`AGEN_ADDR_W-1:0]                 str_offset,
   output logic [`AGEN_SEG_ID_W-1:0]               str_seg
);

   str_ptr_t cur;

   // destination unit during the second cmps uop
   assign cur = ptr[ctrl.second_uop];

   always_comb begin
      case (ctrl.rd_addr_sel)
         2'd0:    mem_rd_addr = seg_sum;
         2'd1:    mem_rd_addr = stack_addr;
         2'd2:    mem_rd_addr = intr_addr;
         default: mem_rd_addr = cur.lin_addr;
      endcase
   end

   // writes only go to segment sum or stack
   assign mem_wr_addr = (ctrl.wr_addr_sel == 2'd1) ? stack_addr : seg_sum;

   assign str_offset = cur.base_offset;
   assign str_seg    = cur.seg_id;

   // string base replaces a while repne is iterating
   assign a_out = (repne & ctrl.steady) ? cur.base_offset : a;
   assign b_out = ctrl.imm1 ? `AGEN_ADDR_W'(1) : b;

endmodule

`default_nettype wire

// File: src/agen_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "agen_defs.svh"

module agen_stage
   import agen_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      v,
   input  logic                      ld_me,
   input  uop_ctrl_t                 uop,
   input  logic [`AGEN_ADDR_W-1:0]   a,
   input  logic [`AGEN_ADDR_W-1:0]   b,
   input  logic [`AGEN_ADDR_W-1:0]   sp,
   input  logic [`AGEN_ADDR_W-1:0]   base_disp,
   input  logic [`AGEN_ADDR_W-1:0]   sib_seg,
   input  logic [`AGEN_ADDR_W-1:0]   sib_si,
   input  logic [`AGEN_SEG_ID_W-1:0] seg1,
   input  logic [15:0]               seg1_base,
   input  logic [15:0]               seg2_base,
   input  logic [`AGEN_ADDR_W-1:0]   intr_addr,
   input  logic                      mem_rd,
   input  logic                      mem_wr,
   input  logic [`AGEN_SIZE_W-1:0]   mem_size,
   input  logic                      repne,
   input  logic                      df,
   input  seg_limits_t               seg_limits,
   output logic [`AGEN_ADDR_W-1:0]   mem_rd_addr,
   output logic [`AGEN_ADDR_W-1:0]   mem_wr_addr,
   output logic [`AGEN_ADDR_W-1:0]   a_out,
   output logic [`AGEN_ADDR_W-1:0]   b_out,
   output logic                      seg_limit_exc,
   output logic                      jmp_stall,
   output logic                      v_ld_df
);

   agen_ctrl_t                        ctrl;
   step_t                             step;
   str_ptr_t [`AGEN_NUM_STR_PTRS-1:0] ptr;
   logic [`AGEN_ADDR_W-1:0]           seg_sum;
   logic [`AGEN_ADDR_W-1:0]           stack_addr;
   logic [`AGEN_ADDR_W-1:0]           seg1_lin_base;
   logic [`AGEN_ADDR_W-1:0]           str_offset;
   logic [`AGEN_SEG_ID_W-1:0]         str_seg;

   // segment data holds the base in the upper half
   assign seg1_lin_base = {seg1_base, 16'h0000};
   assign seg_sum       = base_disp + sib_seg;
   assign stack_addr    = {seg2_base, 16'h0000} + sp;

   // shared by both pointer units
   assign step = calc_step(mem_size, df);

   agen_ctrl_decode u_ctrl_decode (
      .v         (v),
      .ld_me     (ld_me),
      .uop       (uop),
      .ctrl      (ctrl),
      .jmp_stall (jmp_stall),
      .v_ld_df   (v_ld_df)
   );

   for (genvar i = 0; i < `AGEN_NUM_STR_PTRS; i++) begin : g_str_ptr
      string_ptr_unit u_str_ptr (
         .clk       (clk),
         .rst_n     (rst_n),
         .load      (ctrl.ptr_load[i]),
         .steady    (ctrl.steady),
         .a         (a),
         .seg_id_in (seg1),
         .seg_base  (seg1_lin_base),
         .step      (step),
         .ptr       (ptr[i])
      );
   end

   seg_limit_check u_seg_limit_check (
      .v             (v),
      .mem_rd        (mem_rd),
      .mem_wr        (mem_wr),
      .ctrl          (ctrl),
      .repne         (repne),
      .seg1          (seg1),
      .mem_size      (mem_size),
      .base_disp     (base_disp),
      .sib_si        (sib_si),
      .sp            (sp),
      .str_offset    (str_offset),
      .str_seg       (str_seg),
      .seg_limits    (seg_limits),
      .seg_limit_exc (seg_limit_exc)
   );

   addr_route u_addr_route (
      .ctrl        (ctrl),
      .ptr         (ptr),
      .seg_sum     (seg_sum),
      .stack_addr  (stack_addr),
      .intr_addr   (intr_addr),
      .a           (a),
      .b           (b),
      .repne       (repne),
      .mem_rd_addr (mem_rd_addr),
      .mem_wr_addr (mem_wr_addr),
      .a_out       (a_out),
      .b_out       (b_out),
      .str_offset  (str_offset),
      .str_seg     (str_seg)
   );

endmodule

`default_nettype wire

// File: tests/tb_agen_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "agen_defs.svh"

module tb_agen_stage
   import agen_pkg::*;
();

   localparam int CLK_PERIOD  = 4;
   localparam int TEST_CYCLES = 120;

   logic                      clk;
   logic                      rst_n;
   logic                      v;
   logic                      ld_me;
   uop_ctrl_t                 uop;
   logic [`AGEN_ADDR_W-1:0]   a;
   logic [`AGEN_ADDR_W-1:0]   b;
   logic [`AGEN_ADDR_W-1:0]   sp;
   logic [`AGEN_ADDR_W-1:0]   base_disp;
   logic [`AGEN_ADDR_W-1:0]   sib_seg;
   logic [`AGEN_ADDR_W-1:0]   sib_si;
   logic [`AGEN_SEG_ID_W-1:0] seg1;
   logic [15:0]               seg1_base;
   logic [15:0]               seg2_base;
   logic [`AGEN_ADDR_W-1:0]   intr_addr;
   logic                      mem_rd;
   logic                      mem_wr;
   logic [`AGEN_SIZE_W-1:0]   mem_size;
   logic                      repne;
   logic                      df;
   seg_limits_t               seg_limits;
   logic [`AGEN_ADDR_W-1:0]   mem_rd_addr;
   logic [`AGEN_ADDR_W-1:0]   mem_wr_addr;
   logic [`AGEN_ADDR_W-1:0]   a_out;
   logic [`AGEN_ADDR_W-1:0]   b_out;
   logic                      seg_limit_exc;
   logic                      jmp_stall;
   logic                      v_ld_df;

   // reference pointer state per unit (0 source and 1 destination)
   logic [31:0] model_ptr [2];
   logic [31:0] model_lin [2];
   logic [2:0]  model_seg [2];
   logic [31:0] lfsr_state;

   agen_stage uut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_word(input int nbits);
      logic [31:0] word;
      logic        bit_out;
      word = '0;
      for (int n = 0; n < nbits; n++) begin
         bit_out = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (bit_out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
         end
         word = {word[30:0], bit_out};
      end
      return word;
   endfunction

   // expected signed step for a size code and direction
   function automatic logic [31:0] exp_step(input int sz, input logic dir);
      int mag;
      mag = (sz == 0) ? 1 : ((sz == 1) ? 2 : 4);
      return dir ? 32'(-mag) : 32'(mag);
   endfunction

   task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "%s mismatch", what);
      end
   endtask

   task automatic expect_bit(input string what, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "%s mismatch", what);
      end
   endtask

   // wait for the edge plus 1 ns and idle the control bits
   task automatic start_cycle();
      @(posedge clk);
      #1;
      v = 1'b0;
      ld_me = 1'b0;
      uop = '0;
      mem_rd = 1'b0;
      mem_wr = 1'b0;
      repne = 1'b0;
   endtask

   task automatic set_cmps_uop(input int u, input logic steady);
      v = 1'b1;
      ld_me = 1'b1;
      repne = 1'b1;
      uop.rd_addr_sel = 2'd3;
      uop.repne_steady = steady;
      uop.cmps_first = (u == 0);
      uop.cmps_second = (u == 1);
   endtask

   task automatic strobes_after_reset();
      uop = '1;
      #1;
      expect_bit("jmp_stall after reset", jmp_stall, 1'b0);
      expect_bit("v_ld_df after reset", v_ld_df, 1'b0);
   endtask

   task automatic seg_stack_addresses();
      logic [31:0] seg_sum;
      logic [31:0] stack_sum;
      for (int i = 0; i < 8; i++) begin
         start_cycle();
         v = 1'b1;
         uop.rd_addr_sel = {1'b0, i[0]};
         uop.wr_addr_sel = {1'b0, i[1]};
         base_disp = rand_word(32);
         sib_seg = rand_word(32);
         sp = rand_word(32);
         seg2_base = 16'(rand_word(16));
         #1;
         seg_sum = base_disp + sib_seg;
         stack_sum = {seg2_base, 16'h0000} + sp;
         compare_word("read address", mem_rd_addr, i[0] ? stack_sum : seg_sum);
         compare_word("write address", mem_wr_addr, i[1] ? stack_sum : seg_sum);
      end
   endtask

   task automatic intr_and_operands();
      for (int i = 0; i < 4; i++) begin
         start_cycle();
         v = 1'b1;
         uop.rd_addr_sel = 2'd2;
         uop.mux_imm1 = i[0];
         intr_addr = rand_word(32);
         a = rand_word(32);
         b = rand_word(32);
         #1;
         compare_word("interrupt address", mem_rd_addr, intr_addr);
         compare_word("b operand", b_out, i[0] ? 32'd1 : b);
         compare_word("a operand", a_out, a);
      end
   endtask

   // first src and dst uops followed by steady iterations
   task automatic repne_cmps_sequence();
      logic [31:0] st;
      logic [31:0] base;
      for (int sz = 0; sz < 3; sz++) begin
         for (int d = 0; d < 2; d++) begin
            st = exp_step(sz, 1'(d));
            for (int it = 0; it < 4; it++) begin
               for (int u = 0; u < 2; u++) begin
                  start_cycle();
                  set_cmps_uop(u, it != 0);
                  mem_size = 2'(sz);
                  df = 1'(d);
                  a = rand_word(32);
                  seg1 = 3'(rand_word(3));
                  seg1_base = 16'(rand_word(16));
                  #1;
                  base = {seg1_base, 16'h0000};
                  if (it == 0) begin
                     compare_word("first string address", mem_rd_addr, a + base);
                     compare_word("first a_out", a_out, a);
                     model_ptr[u] = a + st;
                     model_lin[u] = a + base + st;
                     model_seg[u] = seg1;
                  end else begin
                     compare_word("steady string address", mem_rd_addr, model_lin[u] + st);
                     compare_word("steady a_out", a_out, model_ptr[u]);
                     model_ptr[u] = model_ptr[u] + st;
                     model_lin[u] = model_lin[u] + st;
                  end
               end
            end
         end
      end
   endtask

   // ld_me low for three cycles then v low for three
   task automatic back_pressure_hold();
      logic [31:0] st;
      st = exp_step(2, 1'b1);
      for (int c = 0; c < 8; c++) begin
         start_cycle();
         set_cmps_uop(0, 1'b1);
         mem_size = 2'd2;
         df = 1'b1;
         v = (c < 3) || (c >= 6);
         ld_me = (c >= 3);
         a = rand_word(32);
         #1;
         compare_word("held string address", mem_rd_addr, model_lin[0] + st);
         compare_word("held a_out", a_out, model_ptr[0]);
         if (v && ld_me) begin
            model_ptr[0] = model_ptr[0] + st;
            model_lin[0] = model_lin[0] + st;
         end
      end
   endtask

   task automatic segment_limits();
      logic [31:0] lim;
      logic [31:0] si;
      logic [31:0] last;
      for (int sz = 0; sz < 3; sz++) begin
         last = exp_step(sz, 1'b0) - 32'd1;
         lim = {4'h1, 28'(rand_word(28))};
         si = {24'h0, 8'(rand_word(8))};
         for (int past = 0; past < 2; past++) begin
            start_cycle();
            mem_size = 2'(sz);
            df = 1'b0;
            v = 1'b1;
            mem_rd = 1'b1;
            seg1 = 3'd3;
            seg_limits = '1;
            seg_limits[3] = lim;
            sib_si = si;
            base_disp = lim - last - si + 32'(past);
            #1;
            expect_bit("segment sum limit", seg_limit_exc, past == 1);
         end
         for (int past = 0; past < 2; past++) begin
            start_cycle();
            v = 1'b1;
            mem_wr = 1'b1;
            uop.wr_addr_sel = 2'd1;
            seg_limits = '1;
            seg_limits[`AGEN_SEG_SS] = lim;
            sp = lim - last + 32'(past);
            #1;
            expect_bit("stack limit", seg_limit_exc, past == 1);
         end
         // load the source pointer so its stored offset ends at lim
         start_cycle();
         set_cmps_uop(0, 1'b0);
         seg1 = 3'd5;
         a = lim - last - exp_step(sz, 1'b0);
         #1;
         model_ptr[0] = a + exp_step(sz, 1'b0);
         model_seg[0] = seg1;
         for (int past = 0; past < 2; past++) begin
            start_cycle();
            set_cmps_uop(0, 1'b1);
            ld_me = 1'b0;
            mem_rd = 1'b1;
            seg1 = 3'd6;
            seg_limits = '1;
            seg_limits[6] = '0;
            seg_limits[model_seg[0]] = lim - 32'(past);
            #1;
            compare_word("string offset", a_out, model_ptr[0]);
            expect_bit("string limit", seg_limit_exc, past == 1);
         end
      end
      // zero limit gated by v and by the access strobes
      for (int k = 0; k < 3; k++) begin
         start_cycle();
         v = (k != 0);
         mem_rd = (k != 1);
         seg1 = 3'd3;
         seg_limits[3] = '0;
         base_disp = 32'h100;
         sib_si = '0;
         #1;
         expect_bit("gated limit check", seg_limit_exc, k == 2);
      end
   endtask

   task automatic strobe_causes();
      for (int c = 0; c < 3; c++) begin
         start_cycle();
         v = 1'b1;
         uop.jmp_stall = (c == 0);
         uop.near_ret = (c == 1);
         uop.far_ret = (c == 2);
         #1;
         expect_bit("jmp_stall cause", jmp_stall, 1'b1);
         expect_bit("v_ld_df idle", v_ld_df, 1'b0);
      end
      for (int k = 0; k < 8; k++) begin
         start_cycle();
         v = k[0];
         uop.ld_flags = k[1];
         uop.df_affected = k[2];
         uop.jmp_stall = 1'b1;
         #1;
         expect_bit("v_ld_df", v_ld_df, &k[2:0]);
         expect_bit("jmp_stall gated by v", jmp_stall, k[0]);
      end
   endtask

   initial begin
      #(TEST_CYCLES * CLK_PERIOD + 100);
      $display("TB FAILED");
      $fatal(1, "watchdog timeout, the tests did not finish in time");
   end

   initial begin
      lfsr_state = 32'd8;
      rst_n = 1'b0;
      v = 1'b0;
      ld_me = 1'b0;
      uop = '0;
      a = '0;
      b = '0;
      sp = '0;
      base_disp = '0;
      sib_seg = '0;
      sib_si = '0;
      seg1 = '0;
      seg1_base = '0;
      seg2_base = '0;
      intr_addr = '0;
      mem_rd = 1'b0;
      mem_wr = 1'b0;
      mem_size = '0;
      repne = 1'b0;
      df = 1'b0;
      seg_limits = '1;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      strobes_after_reset();
      seg_stack_addresses();
      intr_and_operands();
      repne_cmps_sequence();
      back_pressure_hold();
      segment_limits();
      strobe_causes();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/agen_pkg.sv
src/agen_ctrl_decode.sv
src/string_ptr_unit.sv
src/seg_limit_check.sv
src/addr_route.sv
src/agen_stage.sv
tests/tb_agen_stage.sv

// File: Makefile
TOP := tb_agen_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
